// File: hdl/motion_pkg.sv
// ==================================================
// motion types for the base position controller
// sign-magnitude fixed point, default bands, speeds
// and the sequencer state names
// ==================================================

package motion_pkg;

	// field widths of the fixed-point format
	localparam int int_w  = 8;                  // integer bits
	localparam int frac_w = 8;                  // fraction bits
	localparam int fix_w  = 1 + int_w + frac_w; // sign on top, 17 total

	// sign-magnitude value, bit 16 sign, 15..8 int, 7..0 frac
	typedef logic [fix_w-1:0] fix_t;
	// magnitude field alone, what the axis compares work on
	typedef logic [fix_w-2:0] mag_t;

	// ==================================================
	// default tolerances and speeds
	// ==================================================
	localparam fix_t def_pos_tol   = 17'b0_00000101_00000000; // 5 cm on x and y
	localparam fix_t def_ang_tol   = 17'b0_00010100_00000000; // 20 deg on theta
	localparam fix_t def_lin_speed = 17'b0_00110010_00000000; // 50 cm/s
	localparam fix_t def_ang_speed = 17'b0_00000011_00000000; // 3 rad/s

	// one pass of the controller per start
	typedef enum logic [1:0]
	{
		seq_idle,    // waiting for start
		seq_capture, // errors latched at the end of this cycle
		seq_decide,  // command latched at the end of this cycle
		seq_publish  // cmd_valid out
	} seq_state_t;

endpackage

// File: hdl/apb_regs_pkg.sv
// ==================================================
// APB side of the controller, bus widths and the
// register map with control and status bit positions
// ==================================================

package apb_regs_pkg;

	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// goal and measured pose, fix_t in the low bits
	localparam apb_addr_t reg_goal_x  = 8'h00;
	localparam apb_addr_t reg_goal_y  = 8'h04;
	localparam apb_addr_t reg_goal_th = 8'h08;
	localparam apb_addr_t reg_pose_x  = 8'h0C;
	localparam apb_addr_t reg_pose_y  = 8'h10;
	localparam apb_addr_t reg_pose_th = 8'h14;

	localparam apb_addr_t reg_ctrl    = 8'h18; // write-only start
	localparam apb_addr_t reg_status  = 8'h1C;

	// command readback, read-only
	localparam apb_addr_t reg_cmd_vx  = 8'h20;
	localparam apb_addr_t reg_cmd_vy  = 8'h24;
	localparam apb_addr_t reg_cmd_wz  = 8'h28;

	localparam int ctrl_start_bit   = 0;
	localparam int stat_busy_bit    = 0;
	localparam int stat_reached_bit = 1;
	localparam int stat_seen_bit    = 2;

endpackage

// File: hdl/pose_regs.sv
// ==================================================
// APB register file of the controller, goal and pose
// storage, start pulse, status and command readback
// ==================================================

`timescale 1ns/1ps

module pose_regs
	import apb_regs_pkg::*, motion_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	// apb slave, zero wait
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	// pose toward the error stage
	output fix_t      goal_x,
	output fix_t      goal_y,
	output fix_t      goal_th,
	output fix_t      pose_x,
	output fix_t      pose_y,
	output fix_t      pose_th,
	output logic      start,
	// back from sequencer and command stage
	input  logic      busy,
	input  logic      cmd_valid,
	input  logic      goal_pending,
	input  fix_t      vx,
	input  fix_t      vy,
	input  fix_t      wz,
	output logic      goal_reached
);

	logic      wr_en;       // write access cycle
	logic      rd_en;       // read access cycle
	logic      start_req;   // start bit written as 1
	logic      cmd_seen;    // a command was published since last start
	apb_data_t status_word;
	apb_data_t rd_mux;

	assign wr_en     = psel && penable && pwrite;
	assign rd_en     = psel && penable && !pwrite;
	assign start_req = wr_en && (paddr == reg_ctrl) && pwdata[ctrl_start_bit];

	// ==================================================
	// goal and pose registers
	// ==================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			goal_x  <= '0;
			goal_y  <= '0;
			goal_th <= '0;
			pose_x  <= '0;
			pose_y  <= '0;
			pose_th <= '0;
		end
		else if (wr_en)
		begin
			case (paddr)
				reg_goal_x:  goal_x  <= pwdata[fix_w-1:0];
				reg_goal_y:  goal_y  <= pwdata[fix_w-1:0];
				reg_goal_th: goal_th <= pwdata[fix_w-1:0];
				reg_pose_x:  pose_x  <= pwdata[fix_w-1:0];
				reg_pose_y:  pose_y  <= pwdata[fix_w-1:0];
				reg_pose_th: pose_th <= pwdata[fix_w-1:0];
				default: ; // read-only and unmapped offsets
			endcase
		end
	end

	// start pulse and sticky status
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			start        <= 1'b0;
			goal_reached <= 1'b0;
			cmd_seen     <= 1'b0;
		end
		else
		begin
			start <= start_req && !busy; // a start during a run is lost
			if (cmd_valid)
			begin
				goal_reached <= !goal_pending;
				cmd_seen     <= 1'b1;
			end
			else if (start)
				cmd_seen <= 1'b0; // new run clears it
		end
	end

	always_comb
	begin
		status_word                   = '0;
		status_word[stat_busy_bit]    = busy;
		status_word[stat_reached_bit] = goal_reached;
		status_word[stat_seen_bit]    = cmd_seen;
	end

	// ==================================================
	// read mux
	// ==================================================
	always_comb
	begin
		case (paddr)
			reg_goal_x:  rd_mux = apb_data_t'(goal_x);
			reg_goal_y:  rd_mux = apb_data_t'(goal_y);
			reg_goal_th: rd_mux = apb_data_t'(goal_th);
			reg_pose_x:  rd_mux = apb_data_t'(pose_x);
			reg_pose_y:  rd_mux = apb_data_t'(pose_y);
			reg_pose_th: rd_mux = apb_data_t'(pose_th);
			reg_ctrl:    rd_mux = '0; // start is write-only
			reg_status:  rd_mux = status_word;
			reg_cmd_vx:  rd_mux = apb_data_t'(vx);
			reg_cmd_vy:  rd_mux = apb_data_t'(vy);
			reg_cmd_wz:  rd_mux = apb_data_t'(wz);
			default:     rd_mux = '0;
		endcase
	end

	assign prdata = rd_en ? rd_mux : '0;

	// access phase only ever follows a selected setup
	a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
		penable |-> psel);

endmodule

// File: hdl/pose_error.sv
// ==================================================
// goal minus pose on x, y and theta in sign-magnitude
// latched once per run when err_en is high
// ==================================================

`timescale 1ns/1ps

module pose_error
	import motion_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic err_en,
	input  fix_t goal_x,
	input  fix_t goal_y,
	input  fix_t goal_th,
	input  fix_t pose_x,
	input  fix_t pose_y,
	input  fix_t pose_th,
	output fix_t err_x,
	output fix_t err_y,
	output fix_t err_th
);

	// a - b, magnitude saturates at all ones
	function automatic fix_t sm_sub(input fix_t a, input fix_t b);
		logic             sa;
		logic             sb;
		logic             sr;
		mag_t             ma;
		mag_t             mb;
		mag_t             mr;
		logic [fix_w-1:0] sum; // carry + magnitude
		sa = a[fix_w-1];
		sb = b[fix_w-1];
		ma = a[fix_w-2:0];
		mb = b[fix_w-2:0];
		sum = {1'b0, ma} + {1'b0, mb};
		if (sa != sb)
		begin
			// opposite signs, magnitudes add
			sr = sa;
			mr = sum[fix_w-1] ? {(fix_w-1){1'b1}} : sum[fix_w-2:0];
		end
		else if (ma >= mb)
		begin
			sr = sa;      // goal magnitude wins
			mr = ma - mb;
		end
		else
		begin
			sr = !sa;     // pose wins, sign flips
			mr = mb - ma;
		end
		if (mr == '0)
			sr = 1'b0; // no negative zero
		return {sr, mr};
	endfunction

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			err_x  <= '0;
			err_y  <= '0;
			err_th <= '0;
		end
		else if (err_en)
		begin
			err_x  <= sm_sub(goal_x, pose_x);
			err_y  <= sm_sub(goal_y, pose_y);
			err_th <= sm_sub(goal_th, pose_th);
		end
	end

endmodule

// File: hdl/error_control.sv
// ==================================================
// axis-priority controller turning the three pose
// errors into one fixed-speed command per update
// y is served first, then x, then rotation
// ==================================================

`timescale 1ns/1ps

module error_control
	import motion_pkg::*;
#(
	parameter fix_t pos_tol   = def_pos_tol,   // x and y band
	parameter fix_t ang_tol   = def_ang_tol,   // theta band
	parameter fix_t lin_speed = def_lin_speed, // magnitude only
	parameter fix_t ang_speed = def_ang_speed
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic cmd_en,
	input  fix_t err_x,
	input  fix_t err_y,
	input  fix_t err_th,
	output fix_t vx,
	output fix_t vy,
	output fix_t wz,
	output logic goal_pending
);

	mag_t mag_x;
	mag_t mag_y;
	mag_t mag_th;
	logic out_x;  // error beyond band
	logic out_y;
	logic out_th;
	fix_t vx_d;
	fix_t vy_d;
	fix_t wz_d;

	assign mag_x  = err_x[fix_w-2:0];
	assign mag_y  = err_y[fix_w-2:0];
	assign mag_th = err_th[fix_w-2:0];

	// equal to tolerance still counts as in band
	assign out_x  = mag_x  > pos_tol[fix_w-2:0];
	assign out_y  = mag_y  > pos_tol[fix_w-2:0];
	assign out_th = mag_th > ang_tol[fix_w-2:0];

	// ==================================================
	// priority rule
	// ==================================================
	always_comb
	begin
		vx_d = '0;
		vy_d = '0;
		wz_d = '0;
		if (out_y)
			vx_d = {err_y[fix_w-1], lin_speed[fix_w-2:0]};   // drive along y error
		else if (out_x)
			vy_d = {!err_x[fix_w-1], lin_speed[fix_w-2:0]};  // base y axis opposes x error
		else if (out_th)
			wz_d = {err_th[fix_w-1], ang_speed[fix_w-2:0]};
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vx           <= '0;
			vy           <= '0;
			wz           <= '0;
			goal_pending <= 1'b0;
		end
		else if (cmd_en)
		begin
			vx           <= vx_d;
			vy           <= vy_d;
			wz           <= wz_d;
			goal_pending <= out_x || out_y || out_th;
		end
	end

	// never two axes moving at once
	a_one_axis: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({|vx, |vy, |wz}));

endmodule

// File: hdl/motion_sequencer.sv
// ==================================================
// control FSM that walks one start through error
// capture, command decide and a single-cycle publish
// ==================================================

`timescale 1ns/1ps

module motion_sequencer
	import motion_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic err_en,
	output logic cmd_en,
	output logic cmd_valid,
	output logic busy
);

	seq_state_t state;
	seq_state_t state_nxt;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= seq_idle;
		else
			state <= state_nxt;
	end

	// ==================================================
	// next state
	// ==================================================
	always_comb
	begin
		state_nxt = state;
		case (state)
			seq_idle:
			begin
				if (start)
					state_nxt = seq_capture;
			end
			seq_capture: state_nxt = seq_decide;
			seq_decide:  state_nxt = seq_publish;
			seq_publish: state_nxt = seq_idle;
			default:     state_nxt = seq_idle;
		endcase
	end

	assign err_en    = (state == seq_capture);
	assign cmd_en    = (state == seq_decide);
	assign cmd_valid = (state == seq_publish);
	// start cycle already counts as busy
	assign busy      = start || (state != seq_idle);

	a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid |=> !cmd_valid);

endmodule

// File: hdl/base_controller_top.sv
// ==================================================
// base position controller, APB registers around the
// error and priority stages, driven by the sequencer
// ==================================================

`timescale 1ns/1ps

module base_controller_top
	import apb_regs_pkg::*, motion_pkg::*;
#(
	parameter fix_t pos_tol   = def_pos_tol,
	parameter fix_t ang_tol   = def_ang_tol,
	parameter fix_t lin_speed = def_lin_speed,
	parameter fix_t ang_speed = def_ang_speed
)
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output fix_t      vx,
	output fix_t      vy,
	output fix_t      wz,
	output logic      cmd_valid,
	output logic      goal_reached
);

	fix_t goal_x;
	fix_t goal_y;
	fix_t goal_th;
	fix_t pose_x;
	fix_t pose_y;
	fix_t pose_th;
	fix_t err_x;
	fix_t err_y;
	fix_t err_th;
	logic start;
	logic busy;
	logic err_en;
	logic cmd_en;
	logic goal_pending;

	// ==================================================
	// register block
	// ==================================================
	pose_regs i_pose_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.goal_x       (goal_x),
		.goal_y       (goal_y),
		.goal_th      (goal_th),
		.pose_x       (pose_x),
		.pose_y       (pose_y),
		.pose_th      (pose_th),
		.start        (start),
		.busy         (busy),
		.cmd_valid    (cmd_valid),
		.goal_pending (goal_pending),
		.vx           (vx),
		.vy           (vy),
		.wz           (wz),
		.goal_reached (goal_reached)
	);

	motion_sequencer i_motion_sequencer (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.err_en    (err_en),
		.cmd_en    (cmd_en),
		.cmd_valid (cmd_valid),
		.busy      (busy)
	);

	// ==================================================
	// datapath, errors then command
	// ==================================================
	pose_error i_pose_error (
		.clk     (clk),
		.rst_n   (rst_n),
		.err_en  (err_en),
		.goal_x  (goal_x),
		.goal_y  (goal_y),
		.goal_th (goal_th),
		.pose_x  (pose_x),
		.pose_y  (pose_y),
		.pose_th (pose_th),
		.err_x   (err_x),
		.err_y   (err_y),
		.err_th  (err_th)
	);

	error_control #(
		.pos_tol   (pos_tol),
		.ang_tol   (ang_tol),
		.lin_speed (lin_speed),
		.ang_speed (ang_speed)
	) i_error_control (
		.clk          (clk),
		.rst_n        (rst_n),
		.cmd_en       (cmd_en),
		.err_x        (err_x),
		.err_y        (err_y),
		.err_th       (err_th),
		.vx           (vx),
		.vy           (vy),
		.wz           (wz),
		.goal_pending (goal_pending)
	);

endmodule

// File: test/tb_base_controller.sv
// ==================================================
// testbench for the base position controller
// covers APB register access, directed priority
// cases and random poses against a reference model
// ==================================================

`timescale 1ns/1ps

module tb_base_controller
	import apb_regs_pkg::*, motion_pkg::*;
;

	// model copies of the bands and speeds in 1/256 units
	localparam int pos_tol_m = 5 * 256;
	localparam int ang_tol_m = 20 * 256;
	localparam int lin_m     = 50 * 256;
	localparam int ang_m     = 3 * 256;

	logic      clk;
	logic      rst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	fix_t      vx;
	fix_t      vy;
	fix_t      wz;
	logic      cmd_valid;
	logic      goal_reached;
	integer    seed;

	base_controller_top i_base_controller_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.vx           (vx),
		.vy           (vy),
		.wz           (wz),
		.cmd_valid    (cmd_valid),
		.goal_reached (goal_reached)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// publish pulse is one cycle wide
	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid |=> !cmd_valid)
	else
	begin
		$display("ERROR at %0t ns: cmd_valid stayed high for two cycles", $time);
		$display("RESULT: FAIL");
		$fatal(1, "cmd_valid pulse too long");
	end

	// ==================================================
	// checks and reference model
	// ==================================================
	task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
		begin
			$display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, act);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// signed value in 1/256 units to sign-magnitude
	function automatic fix_t fix_of(input int v);
		fix_t f;
		f[16]   = (v < 0);
		f[15:0] = 16'((v < 0) ? -v : v);
		return f;
	endfunction

	function automatic fix_t cm(input int c);
		return fix_of(c * 256);
	endfunction

	// plain integer difference with clipped magnitude and positive zero
	function automatic fix_t model_sub(input fix_t a, input fix_t b);
		int va;
		int vb;
		int d;
		va = a[16] ? -int'(a[15:0]) : int'(a[15:0]);
		vb = b[16] ? -int'(b[15:0]) : int'(b[15:0]);
		d  = va - vb;
		if (d > 65535)
			d = 65535;
		if (d < -65535)
			d = -65535;
		return fix_of(d);
	endfunction

	task automatic model_cmd(input fix_t ex, input fix_t ey, input fix_t eth,
		output fix_t mvx, output fix_t mvy, output fix_t mwz, output logic reached);
		mvx     = '0;
		mvy     = '0;
		mwz     = '0;
		reached = 1'b0;
		if (int'(ey[15:0]) > pos_tol_m)
			mvx = fix_of(ey[16] ? -lin_m : lin_m);
		else if (int'(ex[15:0]) > pos_tol_m)
			mvy = fix_of(ex[16] ? lin_m : -lin_m); // against the x error
		else if (int'(eth[15:0]) > ang_tol_m)
			mwz = fix_of(eth[16] ? -ang_m : ang_m);
		else
			reached = 1'b1;
	endtask

	function automatic fix_t rand_fix();
		logic [31:0] r;
		r = $random(seed);
		if (r[31])
			return {r[16], 6'b0, r[9:0]}; // small value that lands in band now and then
		return r[16:0];
	endfunction

	// ==================================================
	// APB and run tasks
	// ==================================================
	task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
		@(negedge clk);
		psel    = 1'b1; // setup
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk);
		penable = 1'b1; // access cycle ends at the next rising edge
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(negedge clk);
		penable = 1'b1;
		#1;
		data = prdata; // mid access cycle
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_read(input apb_addr_t addr, input apb_data_t val, input string name);
		apb_data_t rd;
		write_reg(addr, val);
		read_reg(addr, rd);
		expect_eq(name, val, rd);
	endtask

	// entered one falling edge after the start write edge
	task automatic wait_valid();
		int cycles;
		cycles = 0;
		while (cmd_valid !== 1'b1)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > 20)
			begin
				$display("timeout, cmd_valid did not rise within 20 cycles of start");
				$display("RESULT: FAIL");
				$fatal(1, "no command published");
			end
		end
		expect_eq("cmd_valid latency", 32'd3, 32'(cycles));
	endtask

	task automatic run_case(input fix_t gx, input fix_t gy, input fix_t gth,
		input fix_t px, input fix_t py, input fix_t pth);
		fix_t      mvx;
		fix_t      mvy;
		fix_t      mwz;
		logic      reached;
		apb_data_t rd;
		model_cmd(model_sub(gx, px), model_sub(gy, py), model_sub(gth, pth),
			mvx, mvy, mwz, reached);
		write_reg(reg_goal_x, apb_data_t'(gx));
		write_reg(reg_goal_y, apb_data_t'(gy));
		write_reg(reg_goal_th, apb_data_t'(gth));
		write_reg(reg_pose_x, apb_data_t'(px));
		write_reg(reg_pose_y, apb_data_t'(py));
		write_reg(reg_pose_th, apb_data_t'(pth));
		write_reg(reg_ctrl, 32'h1);
		wait_valid();
		expect_eq("vx", 32'(mvx), 32'(vx));
		expect_eq("vy", 32'(mvy), 32'(vy));
		expect_eq("wz", 32'(mwz), 32'(wz));
		@(negedge clk);
		expect_eq("cmd_valid", 32'd0, 32'(cmd_valid));
		expect_eq("goal_reached", 32'(reached), 32'(goal_reached));
		read_reg(reg_status, rd);
		expect_eq("status", {29'b0, 1'b1, reached, 1'b0}, rd); // cmd_seen set and busy low
		read_reg(reg_cmd_vx, rd);
		expect_eq("cmd_vx", 32'(mvx), rd);
		read_reg(reg_cmd_vy, rd);
		expect_eq("cmd_vy", 32'(mvy), rd);
		read_reg(reg_cmd_wz, rd);
		expect_eq("cmd_wz", 32'(mwz), rd);
	endtask

	// ==================================================
	// stimulus
	// ==================================================
	initial
	begin
		apb_data_t rd;
		fix_t      rnd [0:5];
		seed    = 23736;
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		// reset state
		expect_eq("vx", 32'd0, 32'(vx));
		expect_eq("vy", 32'd0, 32'(vy));
		expect_eq("wz", 32'd0, 32'(wz));
		expect_eq("cmd_valid", 32'd0, 32'(cmd_valid));
		expect_eq("goal_reached", 32'd0, 32'(goal_reached));
		read_reg(reg_status, rd);
		expect_eq("status", 32'd0, rd);
		read_reg(reg_cmd_vx, rd);
		expect_eq("cmd_vx", 32'd0, rd);
		read_reg(reg_cmd_vy, rd);
		expect_eq("cmd_vy", 32'd0, rd);
		read_reg(reg_cmd_wz, rd);
		expect_eq("cmd_wz", 32'd0, rd);

		// register readback
		write_read(reg_goal_x, 32'h0_1A2B, "goal_x");
		write_read(reg_goal_y, 32'h1_0304, "goal_y");
		write_read(reg_goal_th, 32'h0_FFFF, "goal_th");
		write_read(reg_pose_x, 32'h1_8001, "pose_x");
		write_read(reg_pose_y, 32'h0_0055, "pose_y");
		write_read(reg_pose_th, 32'h1_2200, "pose_th");
		write_reg(reg_ctrl, 32'hFFFF_FFFE); // every bit but start
		read_reg(reg_ctrl, rd);
		expect_eq("ctrl", 32'd0, rd);
		write_reg(reg_cmd_vx, 32'h0_1234);
		write_reg(reg_cmd_vy, 32'h1_4321);
		write_reg(reg_cmd_wz, 32'h0_0777);
		read_reg(reg_cmd_vx, rd);
		expect_eq("cmd_vx", 32'd0, rd);
		read_reg(reg_cmd_vy, rd);
		expect_eq("cmd_vy", 32'd0, rd);
		read_reg(reg_cmd_wz, rd);
		expect_eq("cmd_wz", 32'd0, rd);

		// y first where opposite signs add
		run_case(cm(20), cm(3), cm(90), cm(-10), cm(-4), cm(0));
		expect_eq("vx", 32'(cm(50)), 32'(vx));
		run_case(cm(0), cm(-2), cm(-45), cm(40), cm(6), cm(45));
		expect_eq("vx", 32'(cm(-50)), 32'(vx));
		run_case(cm(0), fix_of(5 * 256 + 1), cm(0), cm(0), cm(0), cm(0)); // just past band
		expect_eq("vx", 32'(cm(50)), 32'(vx));

		// x next with y exactly on its band
		run_case(cm(12), cm(10), cm(100), cm(3), cm(5), cm(0));
		expect_eq("vy", 32'(cm(-50)), 32'(vy));
		run_case(cm(-2), cm(7), cm(0), cm(5), cm(7), cm(0));
		expect_eq("vy", 32'(cm(50)), 32'(vy));

		// theta last
		run_case(cm(8), cm(0), cm(10), cm(3), cm(5), cm(40));
		expect_eq("wz", 32'(cm(-3)), 32'(wz));
		run_case(cm(1), cm(1), cm(50), cm(0), cm(0), cm(20));
		expect_eq("wz", 32'(cm(3)), 32'(wz));

		// everything in band with theta on its limit
		run_case(cm(4), cm(-3), cm(30), cm(0), cm(2), cm(10));
		expect_eq("vx", 32'd0, 32'(vx));
		expect_eq("goal_reached", 32'd1, 32'(goal_reached));

		// a start written during the run is dropped
		write_reg(reg_ctrl, 32'h1);
		write_reg(reg_ctrl, 32'h1); // access ends while busy
		expect_eq("cmd_valid", 32'd1, 32'(cmd_valid));
		repeat (12)
		begin
			@(negedge clk);
			expect_eq("cmd_valid", 32'd0, 32'(cmd_valid));
		end

		// random poses against the model
		for (int i = 0; i < 40; i++)
		begin
			for (int k = 0; k < 6; k++)
				rnd[k] = rand_fix();
			run_case(rnd[0], rnd[1], rnd[2], rnd[3], rnd[4], rnd[5]);
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: vlog.f
hdl/motion_pkg.sv
hdl/apb_regs_pkg.sv
hdl/pose_regs.sv
hdl/pose_error.sv
hdl/error_control.sv
hdl/motion_sequencer.sv
hdl/base_controller_top.sv
test/tb_base_controller.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it, the exit status is the verdict
verilator --binary --timing --assert -f vlog.f --top-module tb_base_controller \
	&& ./obj_dir/Vtb_base_controller \
	|| exit 1
